//--- logic/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and address width, every bus in the core is one byte
`define CPU_DATA_W 8

// Data RAM words, fully addressed by an 8 bit MARLO or immed8
`define CPU_RAM_DEPTH 256

// First program word fetched after reset
`define CPU_RESET_PC 8'h00

`endif

//--- logic/cpu_isa_pkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package cpu_isa_pkg;

    // ALU operation, also carries the halt opcode
    typedef enum logic [3:0] {
        OP_PASS_A = 4'd0,
        OP_PASS_B = 4'd1,
        OP_ADD    = 4'd2,
        OP_ADC    = 4'd3,   // Add with stored carry
        OP_SUB    = 4'd4,
        OP_SBC    = 4'd5,   // Subtract with stored carry (c=1 means no borrow)
        OP_AND    = 4'd6,
        OP_OR     = 4'd7,
        OP_XOR    = 4'd8,
        OP_NOT_B  = 4'd9,
        OP_SHL_A  = 4'd10,
        OP_SHR_A  = 4'd11,
        OP_INC_A  = 4'd12,
        OP_DEC_A  = 4'd13,
        OP_HALT   = 4'd14
    } alu_op_e;

    // Execution condition, DI and DO look at the UART status directly
    typedef enum logic [2:0] {
        C_ALWAYS, C_C, C_Z, C_N, C_EQ, C_NE, C_DI, C_DO
    } cond_e;

    // A bus source
    typedef enum logic [2:0] {
        A_REGA, A_REGB, A_REGC, A_REGD, A_MARLO, A_UART, A_ZERO
    } adev_e;

    // B bus source
    typedef enum logic [2:0] {
        B_REGA, B_REGB, B_REGC, B_REGD, B_MARLO, B_RAM, B_IMMED, B_ZERO
    } bdev_e;

    // Result target, low two bits pick the register for T_REGA..T_REGD
    typedef enum logic [2:0] {
        T_REGA, T_REGB, T_REGC, T_REGD, T_MARLO, T_RAM, T_UART, T_PC
    } tdev_e;

    // 32 bit program word
    typedef struct packed {
        alu_op_e                 op;
        cond_e                   cond;
        tdev_e                   targ;
        adev_e                   adev;
        bdev_e                   bdev;
        logic                    set_flags;   // Latch ALU flags when executed
        logic                    direct;      // RAM address from immed8, else MARLO
        logic [5:0]              spare;
        logic [`CPU_DATA_W-1:0]  immed8;
    } instr_t;

endpackage

`default_nettype wire

//--- logic/cpu_bus_pkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package cpu_bus_pkg;

    // ALU status, all active high
    typedef struct packed {
        logic c;    // Carry out, no-borrow on subtract, shifted-out bit on shifts
        logic z;    // Result zero
        logic o;    // Signed overflow
        logic n;    // Result bit 7
        logic gt;   // a > b unsigned
        logic lt;   // a < b unsigned
        logic eq;   // a == b
        logic ne;   // a != b
    } flags_t;

    // One byte on the UART side
    typedef struct packed {
        logic [`CPU_DATA_W-1:0] data;
    } io_byte_t;

endpackage

`default_nettype wire

//--- logic/controller.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module controller (
    input  wire logic                    system_clk,
    input  wire logic                    rst_n,
    input  wire cpu_isa_pkg::instr_t     instr,        // Combinational from program ROM
    input  wire cpu_bus_pkg::flags_t     flags,        // Registered ALU flags
    input  wire logic                    rx_full,      // Receive byte waiting
    input  wire logic                    tx_space,     // Transmit entry free
    input  wire logic [`CPU_DATA_W-1:0]  result,       // Jump target
    output logic [`CPU_DATA_W-1:0]       pc,
    output cpu_isa_pkg::alu_op_e         op,
    output cpu_isa_pkg::adev_e           adev,
    output cpu_isa_pkg::bdev_e           bdev,
    output cpu_isa_pkg::tdev_e           targ,
    output logic [`CPU_DATA_W-1:0]       immed8,
    output logic                         direct,
    output logic                         set_flags_en,
    output logic                         reg_we,
    output logic                         marlo_we,
    output logic                         ram_we,
    output logic                         tx_push,
    output logic                         rx_pop,
    output logic                         halted
);
    import cpu_isa_pkg::*;

    logic cond_true;   // Condition field holds this cycle
    logic stall;       // Waiting on the UART
    logic exec;        // Instruction takes effect
    logic halt_now;    // Executing OP_HALT
    logic commit;      // Executing anything else
    logic pc_load;     // Jump

    // Straight field decode, the datapath selects from these
    assign op     = instr.op;
    assign adev   = instr.adev;
    assign bdev   = instr.bdev;
    assign targ   = instr.targ;
    assign immed8 = instr.immed8;
    assign direct = instr.direct;

    always_comb begin
        case (instr.cond)
            C_ALWAYS: cond_true = 1'b1;
            C_C:      cond_true = flags.c;
            C_Z:      cond_true = flags.z;
            C_N:      cond_true = flags.n;
            C_EQ:     cond_true = flags.eq;
            C_NE:     cond_true = flags.ne;
            C_DI:     cond_true = rx_full;    // Byte ready to read
            C_DO:     cond_true = tx_space;   // Room to send
            default:  cond_true = 1'b0;
        endcase
    end

    // Stall regardless of condition, so a skipped UART access still waits
    assign stall = ((instr.adev == A_UART) && !rx_full) ||
                   ((instr.targ == T_UART) && !tx_space);

    assign exec     = !halted && cond_true && !stall;
    assign halt_now = exec && (instr.op == OP_HALT);
    assign commit   = exec && (instr.op != OP_HALT);   // Halt writes nothing

    // One strobe per target device
    assign reg_we   = commit && (instr.targ inside {T_REGA, T_REGB, T_REGC, T_REGD});
    assign marlo_we = commit && (instr.targ == T_MARLO);
    assign ram_we   = commit && (instr.targ == T_RAM);
    assign tx_push  = commit && (instr.targ == T_UART);
    assign pc_load  = commit && (instr.targ == T_PC);

    assign rx_pop       = commit && (instr.adev == A_UART);   // Consume byte once used
    assign set_flags_en = commit && instr.set_flags;          // Skipped instr keeps flags

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= `CPU_RESET_PC;
            halted <= 1'b0;
        end else begin
            if (halt_now) begin
                halted <= 1'b1;   // Sticky until reset
            end
            if (pc_load) begin
                pc <= result;
            end else if (!halted && !stall && !halt_now) begin
                pc <= pc + 1'b1;   // Also taken when the condition fails
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module alu (
    input  wire logic                    system_clk,
    input  wire logic                    rst_n,
    input  wire cpu_isa_pkg::alu_op_e    op,
    input  wire logic [`CPU_DATA_W-1:0]  a,
    input  wire logic [`CPU_DATA_W-1:0]  b,
    input  wire logic                    set_flags_en,   // Already qualified by exec
    output logic [`CPU_DATA_W-1:0]       result,
    output cpu_bus_pkg::flags_t          flags
);
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    localparam int MSB = `CPU_DATA_W - 1;

    logic [`CPU_DATA_W:0] sum;      // Extra top bit is carry out
    logic                 c_next;
    logic                 o_next;
    flags_t               flags_d;

    always_comb begin
        sum    = '0;
        c_next = 1'b0;
        o_next = 1'b0;
        result = '0;   // Halt drives zero
        case (op)
            OP_PASS_A: result = a;
            OP_PASS_B: result = b;
            OP_ADD, OP_ADC: begin
                sum    = {1'b0, a} + {1'b0, b} + ((op == OP_ADC) ? flags.c : 1'b0);
                result = sum[MSB:0];
                c_next = sum[`CPU_DATA_W];
                o_next = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
            end
            OP_SUB, OP_SBC: begin
                // a + ~b + 1, SBC borrows when stored c is low
                sum    = {1'b0, a} + {1'b0, ~b} + ((op == OP_SUB) ? 1'b1 : flags.c);
                result = sum[MSB:0];
                c_next = sum[`CPU_DATA_W];
                o_next = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
            end
            OP_AND:   result = a & b;
            OP_OR:    result = a | b;
            OP_XOR:   result = a ^ b;
            OP_NOT_B: result = ~b;
            OP_SHL_A: {c_next, result} = {a, 1'b0};   // Bit 7 falls into c
            OP_SHR_A: {result, c_next} = {1'b0, a};   // Bit 0 falls into c
            OP_INC_A: result = a + 1'b1;
            OP_DEC_A: result = a - 1'b1;
            default:  result = '0;
        endcase
    end

    always_comb begin
        flags_d.c  = c_next;
        flags_d.z  = (result == '0);
        flags_d.o  = o_next;
        flags_d.n  = result[MSB];
        flags_d.gt = (a > b);   // Compares use the bus values, not the result
        flags_d.lt = (a < b);
        flags_d.eq = (a == b);
        flags_d.ne = (a != b);
    end

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (set_flags_en) begin
            flags <= flags_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module register_file (
    input  wire logic                    system_clk,
    input  wire logic                    rst_n,
    input  wire logic                    we,
    input  wire logic [1:0]              wr_addr,
    input  wire logic [`CPU_DATA_W-1:0]  wr_data,
    input  wire logic [1:0]              rd_a_addr,   // A bus port
    input  wire logic [1:0]              rd_b_addr,   // B bus port
    output logic [`CPU_DATA_W-1:0]       rd_a_data,
    output logic [`CPU_DATA_W-1:0]       rd_b_data
);

    logic [`CPU_DATA_W-1:0] regs [4];   // REGA..REGD

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // No write bypass, a new value shows up the cycle after the write
    assign rd_a_data = regs[rd_a_addr];
    assign rd_b_data = regs[rd_b_addr];

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module data_ram (
    input  wire logic                              system_clk,
    input  wire logic                              we,
    input  wire logic [$clog2(`CPU_RAM_DEPTH)-1:0] addr,      // immed8 or MARLO
    input  wire logic [`CPU_DATA_W-1:0]            wr_data,
    output logic [`CPU_DATA_W-1:0]                 rd_data
);

    logic [`CPU_DATA_W-1:0] mem [`CPU_RAM_DEPTH];

    always_ff @(posedge system_clk) begin
        if (we) begin
            mem[addr] <= wr_data;
        end
    end

    // Async read so B_RAM feeds the ALU in the same cycle
    assign rd_data = mem[addr];

endmodule

`default_nettype wire

//--- logic/uart_port.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module uart_port (
    input  wire logic                    system_clk,
    input  wire logic                    rst_n,
    input  wire logic                    rx_valid,
    input  wire cpu_bus_pkg::io_byte_t   rx_byte,
    input  wire logic                    rx_pop,     // Core consumed rx_data
    input  wire logic                    tx_push,    // Core writes tx_data
    input  wire logic [`CPU_DATA_W-1:0]  tx_data,
    input  wire logic                    tx_ready,
    output logic                         rx_ready,
    output logic                         rx_full,
    output logic [`CPU_DATA_W-1:0]       rx_data,
    output logic                         tx_valid,
    output cpu_bus_pkg::io_byte_t        tx_byte,
    output logic                         tx_space
);
    import cpu_bus_pkg::*;

    io_byte_t rx_buf;
    io_byte_t tx_buf;
    logic     rx_take;   // Receive handshake
    logic     tx_done;   // Transmit handshake

    assign rx_ready = !rx_full;   // Single entry, only accept when empty
    assign rx_take  = rx_valid && rx_ready;
    assign tx_done  = tx_valid && tx_ready;
    assign tx_space = !tx_valid;  // Frees the cycle after tx_done

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_full  <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            // Take and pop never coincide since rx_ready is low when full
            if (rx_take)     rx_full <= 1'b1;
            else if (rx_pop) rx_full <= 1'b0;
            // Push only issued with tx_space, so never while tx_valid
            if (tx_push)      tx_valid <= 1'b1;
            else if (tx_done) tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge system_clk) begin
        if (rx_take) rx_buf <= rx_byte;
        if (tx_push) tx_buf.data <= tx_data;   // Held until the handshake
    end

    assign rx_data = rx_buf.data;
    assign tx_byte = tx_buf;

endmodule

`default_nettype wire

//--- logic/cpu.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu (
    input  wire logic                    system_clk,
    input  wire logic                    rst_n,
    input  wire cpu_isa_pkg::instr_t     instr,      // External ROM word at pc
    input  wire logic                    rx_valid,
    input  wire cpu_bus_pkg::io_byte_t   rx_byte,
    input  wire logic                    tx_ready,
    output logic [`CPU_DATA_W-1:0]       pc,
    output logic                         rx_ready,
    output logic                         tx_valid,
    output cpu_bus_pkg::io_byte_t        tx_byte,
    output logic                         halted
);
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    alu_op_e                op;
    adev_e                  adev;
    bdev_e                  bdev;
    tdev_e                  targ;
    flags_t                 flags;
    logic [`CPU_DATA_W-1:0] immed8, result, abus, bbus;
    logic [`CPU_DATA_W-1:0] rf_a, rf_b, ram_rd, ram_addr, marlo, rx_data;
    logic                   direct, set_flags_en, reg_we, marlo_we, ram_we;
    logic                   tx_push, rx_pop, rx_full, tx_space;

    controller u_controller (
        .system_clk, .rst_n, .instr, .flags, .rx_full, .tx_space, .result,
        .pc, .op, .adev, .bdev, .targ, .immed8, .direct, .set_flags_en,
        .reg_we, .marlo_we, .ram_we, .tx_push, .rx_pop, .halted
    );

    alu u_alu (.system_clk, .rst_n, .op, .a(abus), .b(bbus), .set_flags_en, .result, .flags);

    register_file u_regs (
        .system_clk, .rst_n, .we(reg_we), .wr_addr(targ[1:0]), .wr_data(result),
        .rd_a_addr(adev[1:0]), .rd_b_addr(bdev[1:0]),   // Low bits index REGA..REGD
        .rd_a_data(rf_a), .rd_b_data(rf_b)
    );

    data_ram u_ram (.system_clk, .we(ram_we), .addr(ram_addr), .wr_data(result), .rd_data(ram_rd));

    uart_port u_uart (
        .system_clk, .rst_n, .rx_valid, .rx_byte, .rx_pop, .tx_push, .tx_data(result),
        .tx_ready, .rx_ready, .rx_full, .rx_data, .tx_valid, .tx_byte, .tx_space
    );

    always_comb begin
        case (adev)
            A_REGA, A_REGB, A_REGC, A_REGD: abus = rf_a;
            A_MARLO: abus = marlo;     // Lets MARLO be stepped through the ALU
            A_UART:  abus = rx_data;
            default: abus = '0;        // A_ZERO
        endcase
    end

    always_comb begin
        case (bdev)
            B_REGA, B_REGB, B_REGC, B_REGD: bbus = rf_b;
            B_MARLO: bbus = marlo;
            B_RAM:   bbus = ram_rd;
            B_IMMED: bbus = immed8;
            default: bbus = '0;        // B_ZERO
        endcase
    end

    // Direct uses immed8 as address, otherwise register indirect via MARLO
    assign ram_addr = direct ? immed8 : marlo;

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n)        marlo <= '0;
        else if (marlo_we) marlo <= result;
    end

endmodule

`default_nettype wire

//--- test/cpu_tb.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_tb;
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    logic                   system_clk, rst_n;
    logic                   rx_valid, rx_ready, tx_ready, tx_valid, halted;
    logic [`CPU_DATA_W-1:0] pc;
    instr_t                 instr;
    io_byte_t               rx_byte, tx_byte;

    instr_t          rom [256];        // Program ROM model
    io_byte_t        rx_q [$];         // Bytes still to offer on rx
    io_byte_t        exp_q [$];        // Expected tx bytes in order
    int              grp_q [$];        // Test group of each expected byte
    logic [8*16-1:0] grp_name [16];
    int              grp_left [16];
    int              grp_err [16];
    int              n_grp, n_rec, n_pass, n_fail;
    logic            expect_halt;
    logic            tx_hold;          // Byte waited on tx last cycle
    io_byte_t        held_byte;

    cpu dut_i (
        .system_clk, .rst_n, .instr, .rx_valid, .rx_byte, .tx_ready,
        .pc, .rx_ready, .tx_valid, .tx_byte, .halted
    );

    always #10 system_clk = ~system_clk;

    assign instr = rom[pc];   // Combinational fetch

    task automatic check_byte(input string sig, input io_byte_t exp, input io_byte_t got,
                              output bit ok);
        ok = (exp === got);
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("ERR %0s exp 0x%02h got 0x%02h", sig, exp.data, got.data);
        end
    endtask

    task automatic check_halt(input logic exp, input logic got);
        if (exp === got) begin
            n_pass++;
            $display("halt: pass");
        end else if (exp) begin
            n_fail++;
            $display("halted never rose after the HALT instruction");
        end else begin
            n_fail++;
            $display("ERR halted exp 0x%0h got 0x%0h", exp, got);
        end
    endtask

    task automatic load_trace();
        int              fd;
        logic [8*16-1:0] kind, name;
        logic [8*200-1:0] rest;
        logic [7:0]      addr;
        logic [31:0]     word;
        io_byte_t        b;
        for (int i = 0; i < 256; i++) begin
            rom[i] = {16'h11C6, 8'h00, 8'(i)};   // Jump to self so a stray PC spins
        end
        fd = $fopen("test/cpu_trace.txt", "r");
        if (fd == 0) begin
            n_fail++;
            $display("cannot open test/cpu_trace.txt");
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                case (kind)
                    "P": begin
                        void'($fscanf(fd, "%h %h", addr, word));
                        rom[addr] = word;
                        n_rec++;
                    end
                    "I": begin
                        void'($fscanf(fd, "%h", b.data));
                        rx_q.push_back(b);
                        n_rec++;
                    end
                    "O": begin
                        void'($fscanf(fd, "%h", b.data));
                        exp_q.push_back(b);
                        grp_q.push_back(n_grp - 1);   // Belongs to the last T
                        grp_left[n_grp-1]++;
                    end
                    "T": begin
                        void'($fscanf(fd, "%s", name));
                        grp_name[n_grp] = name;
                        n_grp++;
                    end
                    "H": expect_halt = 1'b1;
                    default: void'($fgets(rest, fd));   // Comment to end of line
                endcase
            end
            $fclose(fd);
        end
    endtask

    // One rx byte at a time with a random idle gap before each
    task automatic feed_rx();
        io_byte_t b;
        while (rx_q.size() > 0) begin
            b = rx_q.pop_front();
            repeat ($urandom % 6) @(negedge system_clk);
            rx_valid = 1'b1;
            rx_byte  = b;
            while (!rx_ready) @(negedge system_clk);
            @(negedge system_clk);   // Taken at the edge just passed
            rx_valid = 1'b0;
        end
    endtask

    task automatic take_tx(input io_byte_t got);
        io_byte_t e;
        int       g;
        bit       ok;
        if (exp_q.size() == 0) begin
            n_fail++;
            $display("extra byte 0x%02h sent on tx after the last expected byte", got.data);
        end else begin
            e = exp_q.pop_front();
            g = grp_q.pop_front();
            check_byte("tx_byte", e, got, ok);
            if (!ok) grp_err[g]++;
            grp_left[g]--;
            if (grp_left[g] == 0) begin
                $display("%0s: %0s, %0d errors", grp_name[g],
                         (grp_err[g] == 0) ? "pass" : "fail", grp_err[g]);
            end
        end
    endtask

    // Tx sink with random back-pressure and hold checks
    task automatic drain_tx();
        bit ok;
        forever begin
            @(negedge system_clk);
            if (tx_hold && !tx_valid) begin
                n_fail++;
                $display("tx_valid dropped before its byte was taken");
            end
            if (tx_hold) check_byte("tx_byte", held_byte, tx_byte, ok);
            tx_ready = ($urandom % 4) != 0;
            if (tx_valid && tx_ready) take_tx(tx_byte);   // Transfers at next posedge
            tx_hold   = tx_valid && !tx_ready;
            held_byte = tx_byte;
        end
    endtask

    task automatic watchdog(input int cycles);
        #(cycles * 20);
        n_fail++;
        $display("run timed out after %0d cycles, %0d tx bytes never arrived",
                 cycles, exp_q.size());
        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        $display("TEST FAILED");
        $finish;
    endtask

    initial begin
        system_clk  = 1'b0;
        rst_n       = 1'b0;
        rx_valid    = 1'b0;
        rx_byte     = '0;
        tx_ready    = 1'b0;
        tx_hold     = 1'b0;
        expect_halt = 1'b0;
        void'($urandom(70241));
        load_trace();
        repeat (4) @(negedge system_clk);
        rst_n = 1'b1;
        fork
            watchdog(n_rec * 40 + 40);   // Extra 40 covers the halt wait and idle tail
            feed_rx();
            drain_tx();
        join_none
        while (exp_q.size() != 0) @(negedge system_clk);
        // HALT follows the last sent byte within a few cycles
        for (int i = 0; i < 20 && expect_halt && !halted; i++) begin
            @(negedge system_clk);
        end
        check_halt(expect_halt, halted);
        repeat (20) @(negedge system_clk);   // Any transfer here counts as extra
        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/cpu_isa_pkg.sv
logic/cpu_bus_pkg.sv
logic/controller.sv
logic/alu.sv
logic/register_file.sv
logic/data_ram.sv
logic/uart_port.sv
logic/cpu.sv
test/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - logic

sources:
  # Type packages first, the RTL imports them
  - files:
      - logic/cpu_isa_pkg.sv
      - logic/cpu_bus_pkg.sv
  - files:
      - logic/controller.sv
      - logic/alu.sv
      - logic/register_file.sv
      - logic/data_ram.sv
      - logic/uart_port.sv
      - logic/cpu.sv
  - target: test
    files:
      - test/cpu_tb.sv

//--- test/cpu_trace.txt
# Records: P rom_addr instr_word | I rx_byte | O expected_tx_byte | T test_name | H halt
# Hex values, an O follows the instruction or rx byte that produces it
T arith
P 00 1036003C        # REGA = 3C
P 01 107600D5        # REGB = D5
P 02 21818000 O 11   # ADD, c=1
P 03 31818000 O 12   # ADC with c=1
P 04 41818000 O 67   # SUB, borrow so c=0
P 05 51888000 O 98   # SBC b-a with c=0, c=1
P 06 61810000 O 14
P 07 71810000 O FD
P 08 81810000 O E9
P 09 91B10000 O 2A   # NOT REGB
P 0A A1878000 O 78   # SHL REGA
P 0B B18F8000 O 6A   # SHR REGB
P 0C C18F0000 O D6
P 0D D1870000 O 3B
T flags
P 0E 10B6003C        # REGC = 3C
P 0F 40C28000        # REGD = REGA-REGC, z c eq set
P 10 1BF600F0        # NE jump, not taken
P 11 19F60013        # EQ jump over next
P 12 11B600EE
P 13 11B60001 O 01
P 14 15B60002 O 02   # if Z
P 15 13B60003 O 03   # if C
P 16 17B60004        # if N, skipped
P 17 16F68080        # if N with set_flags, skipped so flags keep
P 18 15B60005 O 05   # z still set
P 19 17B60006        # n still clear
P 1A 40C68040        # REGD = 3C-40 = FC, n=1 c=0
P 1B 1BF6001D        # NE jump taken
P 1C 11B600EE
P 1D 079F0000 O FC   # if N send REGD
P 1E 13B60007
P 1F 19B60008
T ram
P 20 11704080        # RAM[80] = REGA
P 21 11714081        # RAM[81] = REGB
P 22 11B54081 O D5
P 23 21854080 O 78   # REGA + RAM[80]
P 24 11360040        # MARLO = 40
P 25 214C0000        # RAM[MARLO] = REGB+MARLO = 15
P 26 C1270000        # MARLO++
P 27 91720000        # RAM[41] = ~REGC = C3
P 28 D1270000        # MARLO--
P 29 11B50000 O 15
P 2A C1270000
P 2B 11B50000 O C3
P 2C 01A70000 O 41
P 2D 11B54040 O 15   # Direct read of the indirect write
T echo
P 2E 10F60005        # REGD = loop count
P 2F C1AF0000        # tx = rx + 1
P 30 D0DF8000        # REGD--
P 31 15F60033        # Z exits the loop
P 32 11F6002F
I 10 O 11
I 20 O 21
I 7F O 80
I FF O 00
I 00 O 01
T burst
P 33 11B6005A O 5A
P 34 11B600A5 O A5
P 35 11B6003C O 3C
P 36 11B600C3 O C3
P 37 11B6000F O 0F
P 38 11B600F0 O F0
P 39 11B60069 O 69
P 3A 11B60096 O 96
P 3B E0000000        # HALT
P 3C 11B600BB        # Never sent
H
